//--- pagerank_defs.svh
//------------------------------------------------
// sizes, lane counts and host register addresses
// for the pagerank scheduler
//------------------------------------------------

`ifndef PAGERANK_DEFS_SVH
`define PAGERANK_DEFS_SVH

// vector length, also number of G rows
`define PR_N          8

// one vector element, one byte
`define PR_ELEM_W     8

// memory and host word width
`define PR_WORD_W     32

// elements per memory word
`define PR_LANES      4

// memory words per vector
`define PR_CHUNKS     2

// byte stride between G rows
`define PR_ROW_BYTES  8

// host register map
`define PR_REG_GO     0
`define PR_REG_BASE_G 1
`define PR_REG_BASE_R 2

`endif

//--- host_msg_pkg.sv
//------------------------------------------------
// host request and response messages
//------------------------------------------------

`default_nettype none

`include "pagerank_defs.svh"

package host_msg_pkg;

  // host transfer direction
  typedef enum logic {
    HOST_RD = 1'b0,
    HOST_WR = 1'b1
  } host_type_e;

  // one word plus address, 65 bits
  typedef struct packed {
    host_type_e             msg_type;
    logic [`PR_WORD_W-1:0]  addr;
    logic [`PR_WORD_W-1:0]  data;
  } host_req_t;

  // type echoed back with a status word
  typedef struct packed {
    host_type_e             msg_type;
    logic [`PR_WORD_W-1:0]  data;
  } host_resp_t;

endpackage

`default_nettype wire

//--- mem_msg_pkg.sv
//------------------------------------------------
// memory request and response messages, word
// union and access kind
//------------------------------------------------

`default_nettype none

`include "pagerank_defs.svh"

package mem_msg_pkg;

  // memory transfer type, 3 bits on the bus
  typedef enum logic [2:0] {
    MEM_RD = 3'd0,
    MEM_WR = 3'd1
  } mem_type_e;

  // one memory word, seen whole or as byte lanes
  // lane 0 sits in the low byte
  typedef union packed {
    logic [`PR_WORD_W-1:0]                 word;
    logic [`PR_LANES-1:0][`PR_ELEM_W-1:0]  lanes;
  } mem_word_u;

  typedef struct packed {
    mem_type_e              msg_type;
    logic [7:0]             opaque;
    logic [`PR_WORD_W-1:0]  addr;
    logic [1:0]             len;
    mem_word_u              data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e              msg_type;
    logic [7:0]             opaque;
    logic                   test;
    logic [1:0]             len;
    mem_word_u              data;
  } mem_resp_t;

  // which access the fsm wants built
  typedef enum logic [1:0] {
    KIND_RD_R = 2'd0,
    KIND_RD_G = 2'd1,
    KIND_WR_R = 2'd2
  } mem_kind_e;

endpackage

`default_nettype wire

//--- host_cmd_port.sv
//------------------------------------------------
// host command port, base registers and the
// start pulse
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module host_cmd_port (
  input  logic                     clk,
  input  logic                     reset,
  input  host_msg_pkg::host_req_t  pr_req,
  input  logic                     pr_req_val,
  output logic                     pr_req_rdy,
  output host_msg_pkg::host_resp_t pr_resp,
  output logic                     pr_resp_val,
  input  logic                     pr_resp_rdy,
  input  logic                     busy,
  output logic                     start,
  output logic [`PR_WORD_W-1:0]    base_g,
  output logic [`PR_WORD_W-1:0]    base_r
);

  import host_msg_pkg::*;

  logic req_go;
  logic is_wr;

  //------------------------------------------------
  // handshake
  //------------------------------------------------

  // idle engine passes val/rdy straight across
  assign pr_req_rdy  = !busy && pr_resp_rdy;
  assign pr_resp_val = !busy && pr_req_val;

  assign req_go = pr_req_val && pr_req_rdy;
  assign is_wr  = (pr_req.msg_type == HOST_WR);

  // go register, one cycle pulse
  assign start = req_go && is_wr && (pr_req.addr == `PR_REG_GO);

  //------------------------------------------------
  // base registers
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
    end else if (req_go && is_wr) begin
      // other addresses acked and dropped
      if (pr_req.addr == `PR_REG_BASE_G) begin
        base_g <= pr_req.data;
      end
      if (pr_req.addr == `PR_REG_BASE_R) begin
        base_r <= pr_req.data;
      end
    end
  end

  //------------------------------------------------
  // response
  //------------------------------------------------

  always_comb begin
    pr_resp.msg_type = pr_req.msg_type;
    // write acks with 0, read answers 1
    if (is_wr) begin
      pr_resp.data = '0;
    end else begin
      pr_resp.data = `PR_WORD_W'(1);
    end
  end

endmodule

`default_nettype wire

//--- sched_fsm.sv
//------------------------------------------------
// run control fsm, chunk and row counters and
// memory handshake
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module sched_fsm (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  output logic                         busy,
  output logic                         mem_req_val,
  input  logic                         mem_req_rdy,
  input  logic                         mem_resp_val,
  output logic                         mem_resp_rdy,
  output mem_msg_pkg::mem_kind_e       mem_kind,
  output logic                         chunk,
  output logic [$clog2(`PR_N)-1:0]     row,
  output logic                         r_load,
  output logic                         g_accum,
  output logic                         first_chunk
);

  import mem_msg_pkg::*;

  localparam int ROW_W = $clog2(`PR_N);
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`PR_N - 1);
  localparam logic LAST_CHUNK = 1'(`PR_CHUNKS - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_R,
    S_WAIT_R,
    S_RD_G,
    S_WAIT_G,
    S_WR,
    S_WAIT_W
  } state_t;

  state_t state;
  state_t state_next;

  logic req_go;
  logic resp_go;
  logic last_row;
  logic last_chunk;

  assign req_go     = mem_req_val && mem_req_rdy;
  assign resp_go    = mem_resp_val && mem_resp_rdy;
  assign last_row   = (row == LAST_ROW);
  assign last_chunk = (chunk == LAST_CHUNK);

  //------------------------------------------------
  // state register and transitions
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_next = S_RD_R;
        end
      end
      S_RD_R: begin
        if (req_go) begin
          state_next = S_WAIT_R;
        end
      end
      S_WAIT_R: begin
        if (resp_go) begin
          state_next = S_RD_G;
        end
      end
      S_RD_G: begin
        if (req_go) begin
          state_next = S_WAIT_G;
        end
      end
      S_WAIT_G: begin
        // next row, next R half, or on to write back
        if (resp_go) begin
          if (!last_row) begin
            state_next = S_RD_G;
          end else if (last_chunk) begin
            state_next = S_WR;
          end else begin
            state_next = S_RD_R;
          end
        end
      end
      S_WR: begin
        if (req_go) begin
          state_next = S_WAIT_W;
        end
      end
      S_WAIT_W: begin
        if (resp_go) begin
          state_next = last_chunk ? S_IDLE : S_WR;
        end
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  //------------------------------------------------
  // chunk and row counters
  //------------------------------------------------

  // both counters are back at 0 when a run ends
  always_ff @(posedge clk) begin
    if (reset) begin
      chunk <= 1'b0;
      row   <= '0;
    end else begin
      case (state)
        S_WAIT_G: begin
          if (resp_go) begin
            if (last_row) begin
              // wraps to 0 after the last half
              row   <= '0;
              chunk <= last_chunk ? 1'b0 : chunk + 1'b1;
            end else begin
              row <= row + ROW_W'(1);
            end
          end
        end
        S_WAIT_W: begin
          if (resp_go) begin
            chunk <= last_chunk ? 1'b0 : chunk + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  //------------------------------------------------
  // outputs
  //------------------------------------------------

  assign busy         = (state != S_IDLE);
  // only one of the two is ever high
  assign mem_req_val  = (state inside {S_RD_R, S_RD_G, S_WR});
  assign mem_resp_rdy = (state inside {S_WAIT_R, S_WAIT_G, S_WAIT_W});

  // datapath strobes on accepted read data
  assign r_load      = (state == S_WAIT_R) && mem_resp_val;
  assign g_accum     = (state == S_WAIT_G) && mem_resp_val;
  assign first_chunk = (chunk == 1'b0);

  always_comb begin
    case (state)
      S_RD_G, S_WAIT_G: mem_kind = KIND_RD_G;
      S_WR, S_WAIT_W:   mem_kind = KIND_WR_R;
      default:          mem_kind = KIND_RD_R;
    endcase
  end

endmodule

`default_nettype wire

//--- matvec_datapath.sv
//------------------------------------------------
// R chunk register, byte dot product, row
// accumulators and write word select
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module matvec_datapath (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_msg_pkg::mem_resp_t    mem_resp,
  input  logic                      r_load,
  input  logic                      g_accum,
  input  logic                      first_chunk,
  input  logic [$clog2(`PR_N)-1:0]  row,
  input  logic                      chunk,
  output logic [`PR_WORD_W-1:0]     result_word
);

  import mem_msg_pkg::*;

  // current R half, lane i is element 4*chunk+i
  logic [`PR_LANES-1:0][`PR_ELEM_W-1:0] r_lanes;

  // one partial result per G row
  logic [`PR_N-1:0][`PR_ELEM_W-1:0] acc;

  logic [`PR_ELEM_W-1:0] dot;

  //------------------------------------------------
  // dot product
  //------------------------------------------------

  // G row half straight off the response
  // 8-bit wrap, only low byte of each product kept
  always_comb begin
    dot = '0;
    for (int i = 0; i < `PR_LANES; i++) begin
      dot = dot + mem_resp.data.lanes[i] * r_lanes[i];
    end
  end

  //------------------------------------------------
  // R half and accumulators
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      r_lanes <= '0;
      acc     <= '0;
    end else begin
      if (r_load) begin
        r_lanes <= mem_resp.data.lanes;
      end
      if (g_accum) begin
        // first half overwrites last run's value
        if (first_chunk) begin
          acc[row] <= dot;
        end else begin
          acc[row] <= acc[row] + dot;
        end
      end
    end
  end

  //------------------------------------------------
  // write back word
  //------------------------------------------------

  // accumulators 4*chunk .. 4*chunk+3, lane 0 lowest
  assign result_word = acc[int'(chunk) * `PR_LANES +: `PR_LANES];

endmodule

`default_nettype wire

//--- mem_req_gen.sv
//------------------------------------------------
// memory address generation and request packing
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module mem_req_gen (
  input  mem_msg_pkg::mem_kind_e    mem_kind,
  input  logic                      chunk,
  input  logic [$clog2(`PR_N)-1:0]  row,
  input  logic [`PR_WORD_W-1:0]     base_g,
  input  logic [`PR_WORD_W-1:0]     base_r,
  input  logic [`PR_WORD_W-1:0]     result_word,
  output mem_msg_pkg::mem_req_t     mem_req
);

  import mem_msg_pkg::*;

  // byte offsets of the current half and row
  logic [`PR_WORD_W-1:0] chunk_off;
  logic [`PR_WORD_W-1:0] row_off;

  assign chunk_off = `PR_WORD_W'(chunk) * `PR_LANES;
  assign row_off   = `PR_WORD_W'(row) * `PR_ROW_BYTES;

  always_comb begin
    mem_req.opaque    = '0;
    mem_req.len       = '0;
    // only looked at on writes
    mem_req.data.word = result_word;
    case (mem_kind)
      KIND_RD_G: begin
        mem_req.msg_type = MEM_RD;
        mem_req.addr     = base_g + row_off + chunk_off;
      end
      KIND_WR_R: begin
        // result goes back over R
        mem_req.msg_type = MEM_WR;
        mem_req.addr     = base_r + chunk_off;
      end
      default: begin
        mem_req.msg_type = MEM_RD;
        mem_req.addr     = base_r + chunk_off;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- pagerank_sched.sv
//------------------------------------------------
// pagerank scheduler top level
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module pagerank_sched (
  input  logic                     clk,
  input  logic                     reset,
  // host side
  input  host_msg_pkg::host_req_t  pr_req,
  input  logic                     pr_req_val,
  output logic                     pr_req_rdy,
  output host_msg_pkg::host_resp_t pr_resp,
  output logic                     pr_resp_val,
  input  logic                     pr_resp_rdy,
  // memory side
  output mem_msg_pkg::mem_req_t    mem_req,
  output logic                     mem_req_val,
  input  logic                     mem_req_rdy,
  input  mem_msg_pkg::mem_resp_t   mem_resp,
  input  logic                     mem_resp_val,
  output logic                     mem_resp_rdy
);

  import mem_msg_pkg::*;

  // config and run control
  logic                      start;
  logic                      busy;
  logic [`PR_WORD_W-1:0]     base_g;
  logic [`PR_WORD_W-1:0]     base_r;

  // fsm to datapath and request packer
  mem_kind_e                 mem_kind;
  logic                      chunk;
  logic [$clog2(`PR_N)-1:0]  row;
  logic                      r_load;
  logic                      g_accum;
  logic                      first_chunk;
  logic [`PR_WORD_W-1:0]     result_word;

  host_cmd_port u_host_cmd_port (
    .clk         (clk),
    .reset       (reset),
    .pr_req      (pr_req),
    .pr_req_val  (pr_req_val),
    .pr_req_rdy  (pr_req_rdy),
    .pr_resp     (pr_resp),
    .pr_resp_val (pr_resp_val),
    .pr_resp_rdy (pr_resp_rdy),
    .busy        (busy),
    .start       (start),
    .base_g      (base_g),
    .base_r      (base_r)
  );

  sched_fsm u_sched_fsm (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_kind     (mem_kind),
    .chunk        (chunk),
    .row          (row),
    .r_load       (r_load),
    .g_accum      (g_accum),
    .first_chunk  (first_chunk)
  );

  matvec_datapath u_matvec_datapath (
    .clk         (clk),
    .reset       (reset),
    .mem_resp    (mem_resp),
    .r_load      (r_load),
    .g_accum     (g_accum),
    .first_chunk (first_chunk),
    .row         (row),
    .chunk       (chunk),
    .result_word (result_word)
  );

  mem_req_gen u_mem_req_gen (
    .mem_kind    (mem_kind),
    .chunk       (chunk),
    .row         (row),
    .base_g      (base_g),
    .base_r      (base_r),
    .result_word (result_word),
    .mem_req     (mem_req)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
//------------------------------------------------
// testbench memory, byte array with random
// response delay and request back-pressure
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module tb_mem_model (
  input  logic                   clk,
  input  logic                   reset,
  input  int                     stall_pct,
  input  mem_msg_pkg::mem_req_t  mem_req,
  input  logic                   mem_req_val,
  output logic                   mem_req_rdy,
  output mem_msg_pkg::mem_resp_t mem_resp,
  output logic                   mem_resp_val,
  input  logic                   mem_resp_rdy
);

  import mem_msg_pkg::*;

  localparam int MEM_BYTES = 256;
  localparam int LOG_DEPTH = 16;

  logic [7:0] mem [0:MEM_BYTES-1];

  // write address log, read by the testbench
  logic [31:0] wr_log [0:LOG_DEPTH-1];
  int          wr_count;
  int          txn_count;

  integer                               seed;
  int                                   rnd;
  int                                   wait_cnt;
  int                                   base_a;
  logic                                 pending;
  mem_type_e                            resp_type;
  logic [`PR_LANES-1:0][`PR_ELEM_W-1:0] resp_word;

  function automatic logic [7:0] peek(input int a);
    return mem[a % MEM_BYTES];
  endfunction

  task automatic poke(input int a, input logic [7:0] d);
    mem[a % MEM_BYTES] = d;
  endtask

  initial begin
    seed         = 67;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    // background fill, every byte from its address
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'(i) ^ 8'hA5;
    end
  end

  //------------------------------------------------
  // accept side, sampled on the rising edge
  //------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      pending   <= 1'b0;
      wr_count  <= 0;
      txn_count <= 0;
      resp_type <= MEM_RD;
      resp_word <= '0;
    end else begin
      if (mem_req_val && mem_req_rdy) begin
        pending   <= 1'b1;
        resp_type <= mem_req.msg_type;
        base_a     = int'(mem_req.addr) % MEM_BYTES;
        if (mem_req.msg_type == MEM_WR) begin
          // little-endian, lane 0 at the lowest byte
          for (int i = 0; i < `PR_LANES; i++) begin
            mem[(base_a + i) % MEM_BYTES] = mem_req.data.lanes[i];
          end
          if (wr_count < LOG_DEPTH) begin
            wr_log[wr_count] <= mem_req.addr;
          end
          wr_count  <= wr_count + 1;
          resp_word <= '0;
        end else begin
          for (int i = 0; i < `PR_LANES; i++) begin
            resp_word[i] <= mem[(base_a + i) % MEM_BYTES];
          end
        end
      end
      if (mem_resp_val && mem_resp_rdy) begin
        pending   <= 1'b0;
        txn_count <= txn_count + 1;
      end
    end
  end

  //------------------------------------------------
  // drive side, on the falling edge
  //------------------------------------------------

  always @(negedge clk) begin
    rnd = $random(seed);
    if (reset) begin
      mem_req_rdy  = 1'b0;
      mem_resp_val = 1'b0;
      wait_cnt     = 0;
    end else if (!pending) begin
      mem_resp_val = 1'b0;
      // stall chance out of 128
      mem_req_rdy  = ((rnd & 127) >= stall_pct);
      // response delay of 0 to 3 cycles
      wait_cnt     = (rnd >>> 8) & 3;
    end else begin
      mem_req_rdy = 1'b0;
      if (wait_cnt == 0) begin
        mem_resp_val = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
    mem_resp.msg_type   = resp_type;
    mem_resp.opaque     = '0;
    mem_resp.test       = 1'b0;
    mem_resp.len        = '0;
    mem_resp.data.lanes = resp_word;
  end

endmodule

`default_nettype wire

//--- tb_pagerank_sched.sv
//------------------------------------------------
// testbench for the pagerank scheduler, directed
// tests, check task, clock, reset and timeout
//------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "pagerank_defs.svh"

module tb_pagerank_sched;

  import host_msg_pkg::*;
  import mem_msg_pkg::*;

  // 4 runs x 20 transactions x 12 cycles, plus host traffic and stalls
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int BASE_G0        = 'h40;
  localparam int BASE_R0        = 'h10;
  localparam int BASE_G1        = 'h80;
  localparam int BASE_R1        = 'hC0;
  localparam int TXN_PER_RUN    = 20;

  logic       clk;
  logic       reset;
  host_req_t  pr_req;
  logic       pr_req_val;
  logic       pr_req_rdy;
  host_resp_t pr_resp;
  logic       pr_resp_val;
  logic       pr_resp_rdy;
  mem_req_t   mem_req;
  logic       mem_req_val;
  logic       mem_req_rdy;
  mem_resp_t  mem_resp;
  logic       mem_resp_val;
  logic       mem_resp_rdy;
  int         stall_pct;

  integer     seed;
  int         errors;
  int         tests_run;
  int         tests_bad;
  int         cycle_count;
  logic [7:0] expect_r [0:`PR_N-1];
  logic [7:0] snapshot [0:BASE_G1-1];

  pagerank_sched DUT (
    .clk          (clk),
    .reset        (reset),
    .pr_req       (pr_req),
    .pr_req_val   (pr_req_val),
    .pr_req_rdy   (pr_req_rdy),
    .pr_resp      (pr_resp),
    .pr_resp_val  (pr_resp_val),
    .pr_resp_rdy  (pr_resp_rdy),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  tb_mem_model u_mem (
    .clk          (clk),
    .reset        (reset),
    .stall_pct    (stall_pct),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  //------------------------------------------------
  // helpers
  //------------------------------------------------

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
      errors = errors + 1;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run = tests_run + 1;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err0);
    end
  endtask

  // one host transfer, response sampled before the accepting edge
  task automatic host_xfer(input host_type_e t, input int addr, input int data,
                           output host_resp_t resp);
    @(negedge clk);
    pr_req.msg_type = t;
    pr_req.addr     = 32'(addr);
    pr_req.data     = 32'(data);
    pr_req_val      = 1'b1;
    #1;
    while (!(pr_req_rdy && pr_resp_val)) begin
      @(negedge clk);
      #1;
    end
    resp = pr_resp;
    @(negedge clk);
    pr_req_val = 1'b0;
  endtask

  // start, then wait for the port to open again
  task automatic run_engine();
    host_resp_t resp;
    int         txn0;
    txn0 = u_mem.txn_count;
    host_xfer(HOST_WR, `PR_REG_GO, 0, resp);
    check_eq(32'(pr_req_rdy), 0, "pr_req_rdy low while busy");
    while (!pr_req_rdy) begin
      @(negedge clk);
    end
    check_eq(32'(u_mem.txn_count - txn0), TXN_PER_RUN, "memory transactions per run");
  endtask

  // result[j] = sum over k of G[j][k] * R[k], mod 256
  task automatic compute_expected(input int bg, input int br);
    logic [7:0] acc;
    for (int j = 0; j < `PR_N; j++) begin
      acc = 8'd0;
      for (int k = 0; k < `PR_N; k++) begin
        acc = acc + u_mem.peek(bg + `PR_ROW_BYTES * j + k) * u_mem.peek(br + k);
      end
      expect_r[j] = acc;
    end
  endtask

  task automatic check_result(input int br);
    for (int j = 0; j < `PR_N; j++) begin
      check_eq(32'(u_mem.peek(br + j)), 32'(expect_r[j]), "result byte");
    end
  endtask

  task automatic fill_random(input int bg, input int br);
    for (int i = 0; i < `PR_N * `PR_ROW_BYTES; i++) begin
      u_mem.poke(bg + i, 8'($random(seed)));
    end
    for (int k = 0; k < `PR_N; k++) begin
      u_mem.poke(br + k, 8'($random(seed)));
    end
  endtask

  //------------------------------------------------
  // tests
  //------------------------------------------------

  task automatic test_reset_idle();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_eq(32'(pr_resp_val), 0, "pr_resp_val after reset");
    check_eq(32'(mem_req_val), 0, "mem_req_val after reset");
    check_eq(32'(mem_resp_rdy), 0, "mem_resp_rdy after reset");
    pr_req.msg_type = HOST_RD;
    pr_req.addr     = 32'd0;
    pr_req.data     = 32'd0;
    pr_req_val      = 1'b1;
    pr_resp_rdy     = 1'b1;
    #1;
    check_eq(32'(pr_req_rdy), 1, "pr_req_rdy follows pr_resp_rdy");
    check_eq(32'(pr_resp_val), 1, "pr_resp_val follows pr_req_val");
    @(negedge clk);
    pr_req_val = 1'b0;
    report_test("reset and idle handshake", err0);
  endtask

  task automatic test_host_regs();
    host_resp_t resp;
    int         err0;
    err0 = errors;
    host_xfer(HOST_WR, `PR_REG_BASE_G, BASE_G0, resp);
    check_eq(32'(resp.msg_type), 32'(HOST_WR), "base_g write type");
    check_eq(resp.data, 0, "base_g write data");
    host_xfer(HOST_WR, `PR_REG_BASE_R, BASE_R0, resp);
    check_eq(32'(resp.msg_type), 32'(HOST_WR), "base_r write type");
    check_eq(resp.data, 0, "base_r write data");
    // size register is gone, still acked
    host_xfer(HOST_WR, 3, 'h1234, resp);
    check_eq(32'(resp.msg_type), 32'(HOST_WR), "address 3 write type");
    check_eq(resp.data, 0, "address 3 write data");
    host_xfer(HOST_RD, `PR_REG_BASE_G, 0, resp);
    check_eq(32'(resp.msg_type), 32'(HOST_RD), "read type");
    check_eq(resp.data, 1, "read data");
    report_test("host register writes", err0);
  endtask

  task automatic test_identity();
    logic [7:0] r_before [0:`PR_N-1];
    int         err0;
    err0 = errors;
    for (int j = 0; j < `PR_N; j++) begin
      for (int k = 0; k < `PR_N; k++) begin
        u_mem.poke(BASE_G0 + `PR_ROW_BYTES * j + k, (j == k) ? 8'd1 : 8'd0);
      end
      r_before[j] = 8'(j * 37 + 5);
      u_mem.poke(BASE_R0 + j, r_before[j]);
    end
    run_engine();
    for (int k = 0; k < `PR_N; k++) begin
      check_eq(32'(u_mem.peek(BASE_R0 + k)), 32'(r_before[k]), "identity keeps R");
    end
    report_test("identity matrix", err0);
  endtask

  task automatic test_random();
    int err0;
    int wr0;
    err0 = errors;
    fill_random(BASE_G0, BASE_R0);
    compute_expected(BASE_G0, BASE_R0);
    wr0 = u_mem.wr_count;
    run_engine();
    check_result(BASE_R0);
    check_eq(32'(u_mem.wr_count - wr0), 2, "writes per run");
    check_eq(u_mem.wr_log[wr0], 32'(BASE_R0), "first write address");
    check_eq(u_mem.wr_log[wr0 + 1], 32'(BASE_R0 + 4), "second write address");
    report_test("random matrix and vector", err0);
  endtask

  task automatic test_iteration();
    int err0;
    err0 = errors;
    // R now holds the previous result
    compute_expected(BASE_G0, BASE_R0);
    run_engine();
    check_result(BASE_R0);
    report_test("second iteration", err0);
  endtask

  task automatic test_new_base();
    host_resp_t resp;
    int         err0;
    err0 = errors;
    stall_pct = 100;
    for (int a = 0; a < BASE_G1; a++) begin
      snapshot[a] = u_mem.peek(a);
    end
    host_xfer(HOST_WR, `PR_REG_BASE_G, BASE_G1, resp);
    host_xfer(HOST_WR, `PR_REG_BASE_R, BASE_R1, resp);
    fill_random(BASE_G1, BASE_R1);
    compute_expected(BASE_G1, BASE_R1);
    run_engine();
    check_result(BASE_R1);
    for (int a = 0; a < BASE_G1; a++) begin
      check_eq(32'(u_mem.peek(a)), 32'(snapshot[a]), "old region untouched");
    end
    report_test("new bases under stalls", err0);
  endtask

  //------------------------------------------------
  // main sequence
  //------------------------------------------------

  initial begin
    reset       = 1'b1;
    pr_req      = '0;
    pr_req_val  = 1'b0;
    pr_resp_rdy = 1'b0;
    stall_pct   = 32;
    seed        = 67;
    errors      = 0;
    tests_run   = 0;
    tests_bad   = 0;
    cycle_count = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_idle();
    test_host_regs();
    test_identity();
    test_random();
    test_iteration();
    test_new_base();
    $display("tests run %0d, tests with errors %0d, checks failed %0d",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
host_msg_pkg.sv
mem_msg_pkg.sv
host_cmd_port.sv
sched_fsm.sv
matvec_datapath.sv
mem_req_gen.sv
pagerank_sched.sv
tb_mem_model.sv
tb_pagerank_sched.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_pagerank_sched
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) pagerank_defs.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
